/* Bender.yml */
package:
  name: hidden_layer_ctrl

sources:
  # Packages come first, the top level last
  - logic/layer_geometry_pkg.sv
  - logic/mem_ctrl_pkg.sv
  - logic/lane_comparator.sv
  - logic/address_decoder.sv
  - logic/activation_mem_ctrl.sv
  - logic/weight_mem_ctrl.sv
  - logic/hidden_layer_ctrl.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/hidden_layer_ctrl_tb.sv

/* bench/ctrl_checks.svh */
`ifndef CTRL_CHECKS_SVH
`define CTRL_CHECKS_SVH

	// Lane memory reads the neuron of the highest slot that asks for it, slot 0 if none does
	function automatic cell_addr_t expected_cell(input neuron_idx_t [LANES-1:0] index,
		input int lane);
		for (int s = LANES - 1; s >= 0; s--)
		begin
			if (int'(index[s]) % LANES == lane)
				return cell_addr_t'(int'(index[s]) / LANES); // Quotient is the cell
		end
		return cell_addr_t'(int'(index[0]) / LANES);
	endfunction

	function automatic int write_collection();
		return (1 + steps) % COLLECTIONS; // Write pointer starts at 1
	endfunction

	// Enables of the part that index d fills
	function automatic logic [LANES-1:0] expected_we(input int d);
		logic [LANES-1:0] we;
		we = '0;
		if (d >= 0 && d < WRITE_CLOCKS)
			we[LANES_PER_PART * (d % FAN_OUT) +: LANES_PER_PART] = '1;
		return we;
	endfunction

	task automatic check_quiet();
		for (int c = 0; c < COLLECTIONS; c++)
		begin
			if (act_mem_o[c].we !== '0)
				report_value($sformatf("act_mem_o[%0d].we", c), act_mem_o[c].we, 0);
		end
		if (weight_o.we_b !== '0)
			report_value("weight_o.we_b", weight_o.we_b, 0);
		if (rff_pt_o !== '0)
			report_value("rff_pt_o", rff_pt_o, 0);
		if (rup_pt_o !== '0)
			report_value("rup_pt_o", rup_pt_o, 0);
		if (mux_sel_o !== '0)
			report_value("mux_sel_o", mux_sel_o, 0);
	endtask

	task automatic check_read_addresses();
		cell_addr_t exp;
		for (int c = 0; c < COLLECTIONS; c++)
		begin
			if (c == write_collection())
				continue; // The written collection carries the write cell instead
			for (int l = 0; l < LANES; l++)
			begin
				exp = expected_cell(memory_index_i, l);
				if (act_mem_o[c].addr[l] !== exp)
					report_value($sformatf("act_mem_o[%0d].addr[%0d]", c, l),
						act_mem_o[c].addr[l], exp);
			end
		end
	endtask

	task automatic check_mux_sel();
		for (int l = 0; l < LANES; l++)
		begin
			if (mux_sel_o[l] !== lane_sel_t'(int'(index_q[l]) % LANES))
				report_value($sformatf("mux_sel_o[%0d]", l), mux_sel_o[l],
					int'(index_q[l]) % LANES);
		end
	endtask

	// Tells through written whether any enable was expected this clock
	task automatic check_act_writes(output int written);
		logic [LANES-1:0] exp;
		written = 0;
		for (int c = 0; c < COLLECTIONS; c++)
		begin
			exp = (c == write_collection()) ? expected_we(write_idx_q2) : '0;
			if (act_mem_o[c].we !== exp)
				report_value($sformatf("act_mem_o[%0d].we", c), act_mem_o[c].we, exp);
			if (exp != '0)
			begin
				written = 1;
				for (int l = 0; l < LANES; l++)
				begin
					if (act_mem_o[c].addr[l] !== cell_addr_t'(write_idx_q2 / FAN_OUT))
						report_value($sformatf("act_mem_o[%0d].addr[%0d]", c, l),
							act_mem_o[c].addr[l], write_idx_q2 / FAN_OUT);
				end
			end
		end
	endtask

	task automatic check_reset();
		for (int i = 0; i < RESET_CYCLES; i++)
		begin
			advance_clock();
			if (i == RESET_CYCLES - 1)
				rst_i = 1'b0; // Last check below already sees the released reset
			@(negedge clk);
			check_quiet();
		end
		advance_clock();
		close_test("reset");
	endtask

	task automatic check_decoder();
		cycle_index_i = cycle_idx_t'(CPC - 1); // Index that writes nothing
		for (int v = 0; v < DECODER_VECTORS; v++)
		begin
			for (int s = 0; s < LANES; s++)
				memory_index_i[s] = neuron_idx_t'(take_bits($bits(neuron_idx_t)));
			@(negedge clk);
			check_read_addresses();
			check_mux_sel(); // Selects of the previous vector
			advance_clock();
		end
		@(negedge clk);
		check_mux_sel();
		advance_clock();
		close_test("decoder");
	endtask

	task automatic check_act_write();
		int written;
		int write_clocks;
		write_clocks = 0;
		for (int t = 0; t < RUN_CLOCKS; t++)
		begin
			cycle_index_i = cycle_idx_t'(t % CPC);
			for (int p = 0; p < LANES_PER_PART; p++)
				act_data_i[p] = act_word_t'(take_bits(WORD_WIDTH));
			@(negedge clk);
			check_act_writes(written);
			if (t >= 2)
				write_clocks += written; // Writes of this cycle start two clocks in
			for (int l = 0; l < LANES; l++)
			begin
				if (act_wdata_o[l] !== act_data_i[l % LANES_PER_PART])
					report_value($sformatf("act_wdata_o[%0d]", l), act_wdata_o[l],
						act_data_i[l % LANES_PER_PART]);
			end
			advance_clock();
		end
		if (write_clocks != WRITE_CLOCKS)
			report_problem($sformatf("one cycle gave %0d write clocks instead of %0d",
				write_clocks, WRITE_CLOCKS));
		close_test("activation write");
	endtask

	task automatic check_pointer_rotation();
		int written;
		for (int s = 0; s < POINTER_STROBES; s++)
		begin
			for (int i = 0; i < CPC; i++)
			begin
				cycle_index_i = cycle_idx_t'(i);
				cycle_clk_i = (i == 0); // Strobe on the first clock of each cycle
				@(negedge clk);
				if (rff_pt_o !== coll_ptr_t'(steps_q % COLLECTIONS))
					report_value("rff_pt_o", rff_pt_o, steps_q % COLLECTIONS);
				if (rup_pt_o !== coll_ptr_t'((steps_q + 2) % COLLECTIONS))
					report_value("rup_pt_o", rup_pt_o, (steps_q + 2) % COLLECTIONS);
				check_act_writes(written);
				// One clock after a strobe the registered pointers still show the old cycle
				for (int c = 0; c < COLLECTIONS; c++)
				begin
					if (i != 1 && act_mem_o[c].we != '0 && (c == rff_pt_o || c == rup_pt_o))
						report_problem($sformatf(
							"collection %0d is written while a read pointer names it", c));
				end
				advance_clock();
			end
		end
		cycle_clk_i = 1'b0;
		close_test("pointer rotation");
	endtask

	task automatic check_weight_mem();
		int idx;
		int enables;
		logic [LANES-1:0] exp_we;
		enables = 0;
		for (int t = 0; t < RUN_CLOCKS; t++)
		begin
			idx = t % CPC;
			cycle_index_i = cycle_idx_t'(idx);
			@(negedge clk);
			exp_we = (idx >= 1 && idx <= CPC - 2) ? '1 : '0; // First and last clock only read
			if (weight_o.we_b !== exp_we)
				report_value("weight_o.we_b", weight_o.we_b, exp_we);
			if (t < CPC && weight_o.we_b != '0)
				enables++;
			for (int l = 0; l < LANES; l++)
			begin
				if (weight_o.r_addr[l] !== wcell_addr_t'(idx % WEIGHT_CELLS))
					report_value($sformatf("weight_o.r_addr[%0d]", l), weight_o.r_addr[l],
						idx % WEIGHT_CELLS);
				if (weight_o.w_addr[l] !== wcell_addr_t'(weight_idx_q % WEIGHT_CELLS))
					report_value($sformatf("weight_o.w_addr[%0d]", l), weight_o.w_addr[l],
						weight_idx_q % WEIGHT_CELLS);
			end
			advance_clock();
		end
		if (enables != CPC - 2)
			report_problem($sformatf("weight enables were high on %0d clocks of a cycle, not %0d",
				enables, CPC - 2));
		close_test("weight memory");
	endtask

`endif

/* bench/hidden_layer_ctrl_tb.sv */
`timescale 1ns/1ns

module hidden_layer_ctrl_tb;

	import layer_geometry_pkg::*;
	import mem_ctrl_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2; // Inputs change this long after the rising edge
	localparam int RESET_CYCLES = 3;
	localparam int DECODER_VECTORS = 64;
	localparam int RUN_CLOCKS = CPC + 2; // One full cycle plus the two-clock write delay
	localparam int POINTER_STROBES = 4;

	// Clocks spent by all tests, each line is one test
	localparam int TEST_CLOCKS = RESET_CYCLES + 1
		+ DECODER_VECTORS + 1
		+ RUN_CLOCKS
		+ POINTER_STROBES * CPC
		+ RUN_CLOCKS;
	localparam int WATCHDOG_CLOCKS = TEST_CLOCKS * 3 / 2; // Half again as margin

	logic clk;
	logic rst_i;
	cycle_idx_t cycle_index_i;
	logic cycle_clk_i;
	neuron_idx_t [LANES-1:0] memory_index_i;
	act_word_t [LANES_PER_PART-1:0] act_data_i;
	act_port_t [COLLECTIONS-1:0] act_mem_o;
	act_word_t [LANES-1:0] act_wdata_o;
	lane_sel_t [LANES-1:0] mux_sel_o;
	coll_ptr_t rff_pt_o;
	coll_ptr_t rup_pt_o;
	weight_port_t weight_o;

	// Expected state, updated at every rising edge
	int write_idx_q1; // Cycle index one edge back, -1 means nothing to write
	int write_idx_q2; // Cycle index two edges back, times the activation writes
	int weight_idx_q; // Cycle index one edge back, gives the weight write address
	int steps; // Pointer steps taken since reset
	int steps_q; // Steps one edge back, what the registered pointers show
	neuron_idx_t [LANES-1:0] index_q; // Neuron indices one edge back

	int errors; // Errors of the running test
	int tests_passed;
	int tests_failed;
	logic [7:0] lfsr_state;

	hidden_layer_ctrl hidden_layer_ctrl_i
	(
		.clk(clk),
		.rst_i(rst_i),
		.cycle_index_i(cycle_index_i),
		.cycle_clk_i(cycle_clk_i),
		.memory_index_i(memory_index_i),
		.act_data_i(act_data_i),
		.act_mem_o(act_mem_o),
		.act_wdata_o(act_wdata_o),
		.mux_sel_o(mux_sel_o),
		.rff_pt_o(rff_pt_o),
		.rup_pt_o(rup_pt_o),
		.weight_o(weight_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Galois form of x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] next_lfsr(input logic [7:0] state);
		if (state[0])
			return (state >> 1) ^ 8'hB8;
		return state >> 1;
	endfunction

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int b = 0; b < count; b++)
		begin
			value = {value[30:0], lfsr_state[0]}; // One LFSR step per bit
			lfsr_state = next_lfsr(lfsr_state);
		end
		return value;
	endfunction

	// Waits for the edge, follows it in the expected state, then moves to the drive point
	task automatic advance_clock();
		@(posedge clk);
		if (rst_i)
		begin
			write_idx_q1 = -1;
			write_idx_q2 = -1;
			weight_idx_q = 0;
			steps = 0;
			steps_q = 0;
			index_q = '0;
		end
		else
		begin
			write_idx_q2 = write_idx_q1;
			write_idx_q1 = int'(cycle_index_i);
			weight_idx_q = int'(cycle_index_i);
			steps_q = steps;
			if (cycle_clk_i)
				steps++; // Pointers step on this edge
			index_q = memory_index_i;
		end
		#DRIVE_DELAY;
	endtask

	task automatic report_value(input string signal, input logic [31:0] got,
		input logic [31:0] expected);
		$display("FAIL %0t ns %s got %0h expected %0h", $time, signal, got, expected);
		errors++;
	endtask

	task automatic report_problem(input string text);
		$display("At %0t ns: %s", $time, text);
		errors++;
	endtask

	task automatic close_test(input string name);
		if (errors == 0)
		begin
			tests_passed++;
			$display("%s: passed", name);
		end
		else
		begin
			tests_failed++;
			$display("%s: %0d errors", name, errors);
		end
		errors = 0;
	endtask

	`include "ctrl_checks.svh"

	initial
	begin
		#(WATCHDOG_CLOCKS * CLK_PERIOD);
		$display("Watchdog expired after %0d clocks, the tests did not complete", WATCHDOG_CLOCKS);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		clk = 1'b0;
		rst_i = 1'b1; // Released inside the reset test
		cycle_index_i = '0;
		cycle_clk_i = 1'b0;
		memory_index_i = '0;
		act_data_i = '0;
		lfsr_state = 8'd63;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		write_idx_q1 = -1;
		write_idx_q2 = -1;
		weight_idx_q = 0;
		steps = 0;
		steps_q = 0;
		index_q = '0;

		check_reset();
		check_decoder();
		check_act_write();
		check_pointer_rotation();
		check_weight_mem();

		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* compile.f */
+incdir+bench
logic/layer_geometry_pkg.sv
logic/mem_ctrl_pkg.sv
logic/lane_comparator.sv
logic/address_decoder.sv
logic/activation_mem_ctrl.sv
logic/weight_mem_ctrl.sv
logic/hidden_layer_ctrl.sv
bench/hidden_layer_ctrl_tb.sv

/* logic/activation_mem_ctrl.sv */
`timescale 1ns/1ns

module activation_mem_ctrl
(
	input  logic clk,
	input  logic rst_i,
	input  layer_geometry_pkg::cycle_idx_t cycle_index_i, // Position in the cycle
	input  logic cycle_clk_i, // Strobe that advances the collection pointers
	// Decoded read cells, shared by every collection that is not written
	input  layer_geometry_pkg::cell_addr_t [layer_geometry_pkg::LANES-1:0] r_addr_i,
	output mem_ctrl_pkg::act_port_t [layer_geometry_pkg::COLLECTIONS-1:0] act_mem_o,
	output layer_geometry_pkg::coll_ptr_t rff_pt_o, // Collection read for feed-forward
	output layer_geometry_pkg::coll_ptr_t rup_pt_o // Collection read for the update
);

	import layer_geometry_pkg::*;

	coll_ptr_t rff_pt; // Feed-forward read collection
	coll_ptr_t w_pt; // Collection written by the previous layer
	coll_ptr_t rup_pt; // Update read collection, also feeds backprop

	cycle_idx_t idx_d1; // Cycle index one clock late
	cycle_idx_t idx_d2; // Cycle index two clocks late, times the writes

	logic [LANES-1:0] part_we; // Lanes of the part being written this clock
	cell_addr_t w_cell; // Cell written this clock on every lane

	// Step one pointer by one collection, wrapping after the last
	function automatic coll_ptr_t next_ptr(input coll_ptr_t ptr);
		if (ptr == COLLECTIONS - 1)
			return '0;
		return coll_ptr_t'(ptr + 1'b1);
	endfunction

	// The three pointers keep a fixed distance of one, so each names a different collection
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			rff_pt <= coll_ptr_t'(0);
			w_pt <= coll_ptr_t'(1); // Write starts one ahead of feed-forward
			rup_pt <= coll_ptr_t'(2);
		end
		else if (cycle_clk_i)
		begin
			rff_pt <= next_ptr(rff_pt); // Last cycle's written data becomes readable
			w_pt <= next_ptr(w_pt);
			rup_pt <= next_ptr(rup_pt);
		end
	end

	// Data from the previous layer lags the index by two clocks
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			idx_d1 <= cycle_idx_t'(CPC - 1); // Park on an index that writes nothing
			idx_d2 <= cycle_idx_t'(CPC - 1);
		end
		else
		begin
			idx_d1 <= cycle_index_i;
			idx_d2 <= idx_d1;
		end
	end

	// Parts are filled in turn, so cell d div FAN_OUT takes FAN_OUT clocks to complete
	always_comb
	begin
		for (int l = 0; l < LANES; l++)
			part_we[l] = (idx_d2 < WRITE_CLOCKS) && ((l / LANES_PER_PART) == (idx_d2 % FAN_OUT));
	end

	assign w_cell = cell_addr_t'(idx_d2 / FAN_OUT); // Same cell on every lane of the part

	// The write collection takes the write cell, the others keep reading
	always_comb
	begin
		for (int c = 0; c < COLLECTIONS; c++)
		begin
			if (coll_ptr_t'(c) == w_pt)
			begin
				act_mem_o[c].we = part_we;
				act_mem_o[c].addr = {LANES{w_cell}};
			end
			else
			begin
				act_mem_o[c].we = '0; // Reads are not destructive, so no enable here
				act_mem_o[c].addr = r_addr_i;
			end
		end
	end

	assign rff_pt_o = rff_pt;
	assign rup_pt_o = rup_pt;

	// A shared collection would mix written data with data still being read
	a_ptr_distinct: assert property (@(posedge clk) disable iff (rst_i)
		(rff_pt != w_pt) && (w_pt != rup_pt) && (rff_pt != rup_pt))
		else $error("Two collection pointers name the same collection");

	// A collection under feed-forward or update read must never take a write
	for (genvar c = 0; c < COLLECTIONS; c++)
	begin : g_we_check
		a_we_not_read: assert property (@(posedge clk) disable iff (rst_i)
			(|act_mem_o[c].we) |-> ((rff_pt != coll_ptr_t'(c)) && (rup_pt != coll_ptr_t'(c))))
			else $error("Collection %0d written while a read pointer names it", c);
	end

endmodule

/* logic/address_decoder.sv */
`timescale 1ns/1ns

module address_decoder
(
	// Interleaved neuron numbers, one per read slot
	input  layer_geometry_pkg::neuron_idx_t [layer_geometry_pkg::LANES-1:0] memory_index_i,
	// Cell to read from each lane memory
	output layer_geometry_pkg::cell_addr_t [layer_geometry_pkg::LANES-1:0] r_addr_o,
	// Select of each output mux, names the lane whose word the slot needs
	output layer_geometry_pkg::lane_sel_t [layer_geometry_pkg::LANES-1:0] mux_sel_o
);

	import layer_geometry_pkg::*;

	lane_sel_t [LANES-1:0] insert; // Slot chosen for every lane memory
	neuron_idx_t [LANES-1:0] picked; // Neuron number that lane memory k must deliver

	// Each lane memory holds neurons whose lane field equals its lane number
	// The comparator finds which slot asks for a neuron of lane k
	// The cell of that neuron is then the read address of lane k
	for (genvar k = 0; k < LANES; k++)
	begin : g_lane
		lane_comparator u_lane_comparator
		(
			.memory_index_i(memory_index_i),
			.lane_i(lane_sel_t'(k)), // Lane number comes from the loop index
			.insert_o(insert[k])
		);

		assign picked[k] = memory_index_i[insert[k]]; // Neuron routed to lane k

		// High bits of the neuron number give its cell inside the lane memory
		assign r_addr_o[k] = picked[k][$bits(neuron_idx_t)-1 -: $bits(cell_addr_t)];

		// Slot k gets its word back from the lane its neuron sits in
		assign mux_sel_o[k] = memory_index_i[k][$bits(lane_sel_t)-1:0];
	end

	// Read addresses go to the memories in the same clock
	// The memory output appears a clock later, so the top delays the selects to meet it
	// Example for four slots
	// Neurons 5, 2, 12, 11 sit in lanes 1, 2, 0, 3 and cells 1, 0, 3, 2
	// Lane 0 reads cell 3 and slot 2 selects lane 0

endmodule

/* logic/hidden_layer_ctrl.sv */
`timescale 1ns/1ns

module hidden_layer_ctrl
(
	input  logic clk,
	input  logic rst_i,
	input  layer_geometry_pkg::cycle_idx_t cycle_index_i, // Position in the cycle
	input  logic cycle_clk_i, // Strobe at the start of every cycle
	// Neuron numbers from the external interleaver
	input  layer_geometry_pkg::neuron_idx_t [layer_geometry_pkg::LANES-1:0] memory_index_i,
	// Activations of one part from the previous layer
	input  layer_geometry_pkg::act_word_t [layer_geometry_pkg::LANES_PER_PART-1:0] act_data_i,
	output mem_ctrl_pkg::act_port_t [layer_geometry_pkg::COLLECTIONS-1:0] act_mem_o,
	// Write data of all lanes, the enables decide which part takes it
	output layer_geometry_pkg::act_word_t [layer_geometry_pkg::LANES-1:0] act_wdata_o,
	output layer_geometry_pkg::lane_sel_t [layer_geometry_pkg::LANES-1:0] mux_sel_o,
	output layer_geometry_pkg::coll_ptr_t rff_pt_o, // Aligned with the memory output
	output layer_geometry_pkg::coll_ptr_t rup_pt_o, // Aligned with the memory output
	output mem_ctrl_pkg::weight_port_t weight_o
);

	import layer_geometry_pkg::*;

	cell_addr_t [LANES-1:0] r_addr_raw; // Decoded read cells
	lane_sel_t [LANES-1:0] mux_sel_raw; // Selects before the latency register
	coll_ptr_t rff_pt_raw;
	coll_ptr_t rup_pt_raw;

	address_decoder u_address_decoder
	(
		.memory_index_i(memory_index_i),
		.r_addr_o(r_addr_raw),
		.mux_sel_o(mux_sel_raw)
	);

	activation_mem_ctrl u_activation_mem_ctrl
	(
		.clk(clk),
		.rst_i(rst_i),
		.cycle_index_i(cycle_index_i),
		.cycle_clk_i(cycle_clk_i),
		.r_addr_i(r_addr_raw),
		.act_mem_o(act_mem_o),
		.rff_pt_o(rff_pt_raw),
		.rup_pt_o(rup_pt_raw)
	);

	weight_mem_ctrl u_weight_mem_ctrl
	(
		.clk(clk),
		.rst_i(rst_i),
		.cycle_index_i(cycle_index_i),
		.weight_o(weight_o)
	);

	// Every part sees the same incoming words
	assign act_wdata_o = {FAN_OUT{act_data_i}};

	// The memories answer one clock after the address, so selects and pointers wait a clock
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			mux_sel_o <= '0;
			rff_pt_o <= '0;
			rup_pt_o <= '0;
		end
		else
		begin
			mux_sel_o <= mux_sel_raw; // Picks the lane for each slot
			rff_pt_o <= rff_pt_raw;
			rup_pt_o <= rup_pt_raw;
		end
	end

endmodule

/* logic/lane_comparator.sv */
`timescale 1ns/1ns

module lane_comparator
(
	input  layer_geometry_pkg::neuron_idx_t [layer_geometry_pkg::LANES-1:0] memory_index_i,
	input  layer_geometry_pkg::lane_sel_t lane_i, // Lane this comparator serves
	output layer_geometry_pkg::lane_sel_t insert_o // Index slot that targets lane_i
);

	import layer_geometry_pkg::*;

	// Lane field of every incoming neuron index
	lane_sel_t [LANES-1:0] lane_field;

	for (genvar i = 0; i < LANES; i++)
	begin : g_field
		assign lane_field[i] = memory_index_i[i][$bits(lane_sel_t)-1:0]; // Low bits pick the lane
	end

	// Scan from the lowest slot up
	// A later match overwrites an earlier one, so the highest matching slot wins
	always_comb
	begin
		insert_o = '0; // Slot 0 is the fallback when nothing matches
		for (int i = 0; i < LANES; i++)
		begin
			if (lane_field[i] == lane_i)
				insert_o = lane_sel_t'(i); // Remember the slot whose neuron lives in this lane
		end
	end

	// The interleaver normally gives each lane exactly one match per clock
	// Several matches only happen for an index pattern that conflicts in the lanes
	// The highest slot is taken then

endmodule

/* logic/layer_geometry_pkg.sv */
package layer_geometry_pkg;

	// Geometry of hidden layer h=1 in a depth-3 network

	localparam int NEURONS = 16; // Neurons held by this layer
	localparam int LANES = 4; // Parallel memories in every collection
	localparam int FAN_OUT = 2; // Parts per collection, one part is written per clock
	localparam int LANES_PER_PART = LANES / FAN_OUT; // Lanes written together in one clock

	// Three activation collections follow from 2*(L-h)-1 with L=3 and h=1
	localparam int COLLECTIONS = 3;

	localparam int CELLS_PER_LANE = NEURONS / LANES; // Depth of one activation memory
	localparam int WRITE_CLOCKS = CELLS_PER_LANE * FAN_OUT; // Clocks that carry data in a cycle

	// Two extra clocks cover the read latency and the write delay
	localparam int CPC = WRITE_CLOCKS + 2;

	localparam int WEIGHT_CELLS = NEURONS * FAN_OUT / LANES; // Entries in each weight memory
	localparam int WORD_WIDTH = 8; // Activation word width

	// Position inside the cycle, counts 0 to CPC-1
	typedef logic [$clog2(CPC)-1:0] cycle_idx_t;

	// Neuron number, the low bits name the lane and the high bits the cell
	typedef logic [$clog2(NEURONS)-1:0] neuron_idx_t;

	typedef logic [$clog2(CELLS_PER_LANE)-1:0] cell_addr_t; // Cell of an activation memory
	typedef logic [$clog2(LANES)-1:0] lane_sel_t; // Lane number, also used as mux select
	typedef logic [$clog2(COLLECTIONS)-1:0] coll_ptr_t; // Collection number

	typedef logic [$clog2(WEIGHT_CELLS)-1:0] wcell_addr_t; // Cell of a weight memory

	typedef logic [WORD_WIDTH-1:0] act_word_t; // One activation word

endpackage

/* logic/mem_ctrl_pkg.sv */
package mem_ctrl_pkg;

	// Control bundle of one activation collection
	// The memories of a collection share no enable, every lane gets its own bit
	typedef struct packed {
		logic [layer_geometry_pkg::LANES-1:0] we; // One enable per lane memory
		// Per-lane cell, either the write cell or the decoded read cell
		layer_geometry_pkg::cell_addr_t [layer_geometry_pkg::LANES-1:0] addr;
	} act_port_t;

	// Control bundle shared by the weight memories of the layer
	// Port A only reads, so it needs the read address and nothing else
	// Port B writes back the updated weight one clock after the read
	typedef struct packed {
		logic [layer_geometry_pkg::LANES-1:0] we_b; // Port-B write enables

		// Port-A read address of each lane
		layer_geometry_pkg::wcell_addr_t [layer_geometry_pkg::LANES-1:0] r_addr;

		// Port-B write address of each lane, the read address one clock late
		layer_geometry_pkg::wcell_addr_t [layer_geometry_pkg::LANES-1:0] w_addr;
	} weight_port_t;

	// act_port_t is 12 bits and weight_port_t is 28 bits for this layer
	// Both are bit-exact images of the memory control pins, most significant field first

endpackage

/* logic/weight_mem_ctrl.sv */
`timescale 1ns/1ns

module weight_mem_ctrl
(
	input  logic clk,
	input  logic rst_i,
	input  layer_geometry_pkg::cycle_idx_t cycle_index_i, // Position in the cycle
	output mem_ctrl_pkg::weight_port_t weight_o // Port controls of all weight memories
);

	import layer_geometry_pkg::*;

	wcell_addr_t rd_cell; // Entry read from every weight memory this clock
	wcell_addr_t rd_cell_q; // Entry read in the clock before, now written back
	logic we_b; // Port-B enable shared by all lanes

	// All memories read the same entry, taken straight from the low index bits
	assign rd_cell = cycle_index_i[$bits(wcell_addr_t)-1:0];

	// Index 0 only reads, and the last index has no pending update
	assign we_b = (cycle_index_i > 0) && (cycle_index_i <= CPC - 2);

	// The updated weight arrives one clock after its read
	always_ff @(posedge clk)
	begin
		if (rst_i)
			rd_cell_q <= '0;
		else
			rd_cell_q <= rd_cell;
	end

	assign weight_o.we_b = {LANES{we_b}}; // One enable per lane memory
	assign weight_o.r_addr = {LANES{rd_cell}};
	assign weight_o.w_addr = {LANES{rd_cell_q}}; // Same entry, written through port B

	// A write at either end of the cycle would hit an entry no read produced
	a_we_window: assert property (@(posedge clk) disable iff (rst_i)
		((cycle_index_i == 0) || (cycle_index_i == CPC - 1)) |-> (weight_o.we_b == '0))
		else $error("Weight write enable high outside the update window");

endmodule
